// ==== source/wb_bus_pkg.sv ====
// wishbone bus widths, engine state codes, command opcodes and the command word union
package wb_bus_pkg;

   // classic wishbone master widths
   localparam int adr_w = 32;
   localparam int dat_w = 32;
   localparam int sel_w = 4;

   // command opcodes sit in the top nibble of a command word
   // any value not listed here behaves as halt
   localparam logic [3:0] op_halt  = 4'd0;
   localparam logic [3:0] op_ldi   = 4'd1;
   localparam logic [3:0] op_add   = 4'd2;
   localparam logic [3:0] op_store = 4'd3;

   // command engine states
   localparam logic [2:0] st_idle   = 3'd0;
   localparam logic [2:0] st_fetch  = 3'd1;
   localparam logic [2:0] st_read   = 3'd2;
   localparam logic [2:0] st_write  = 3'd3;
   localparam logic [2:0] st_halted = 3'd4;

   // one fetched word, two decodings
   // mem form for add and store, imm form for load immediate
   typedef union packed {
      struct packed {
         logic [3:0]  op;
         // byte lanes for store
         logic [3:0]  sel;
         // word address, byte address is this times 4
         logic [23:0] wadr;
      } mem;
      struct packed {
         logic [3:0]  op;
         // zero-extended into the accumulator
         logic [27:0] imm;
      } imm;
   } cmd_word_t;

endpackage

// ==== source/pin_reduce_pkg.sv ====
// widths and fold stages of the serial read-data input and the parity trees
package pin_reduce_pkg;

   // serial input word length, shifted msb first
   localparam int ser_len = 32;

   // width of the bus folded into one signature
   localparam int fold_in_w = 32;

   // first stage folds the bus into one byte
   localparam int fold_w1 = 8;

   // second stage folds that byte into two bits
   localparam int fold_w2 = 2;

   // number of slices xored together at each stage
   localparam int fold_lanes1 = fold_in_w / fold_w1;
   localparam int fold_lanes2 = fold_w1 / fold_w2;

   // stage two output is reduced to the signature pin
   // total latency from bus to signature is two edges

endpackage

// ==== source/cmd_sequencer.sv ====
// command engine: wishbone classic master that fetches, decodes and executes command words
`timescale 1ns/100ps

module cmd_sequencer (
   input  logic                           CLK_I,
   input  logic                           arst_n,
   input  logic                           start,
   input  logic                           ack,
   input  logic [wb_bus_pkg::dat_w-1:0]   dat_i,
   output logic                           cyc,
   output logic                           stb,
   output logic                           we,
   output logic [wb_bus_pkg::adr_w-1:0]   adr,
   output logic [wb_bus_pkg::dat_w-1:0]   dat_o,
   output logic [wb_bus_pkg::sel_w-1:0]   sel,
   output logic                           corerunning
);

   // fsm state
   logic [2:0]                     state;
   // byte address of the next command word
   logic [wb_bus_pkg::adr_w-1:0]   pc;
   // command being executed
   wb_bus_pkg::cmd_word_t          cmd_q;
   // accumulator
   logic [wb_bus_pkg::dat_w-1:0]   acc;

   // read data viewed as a command word
   wb_bus_pkg::cmd_word_t          fetched;
   // byte address of the memory operand
   logic [wb_bus_pkg::adr_w-1:0]   mem_adr;

   assign fetched = dat_i;

   // word address times 4, top bits zero
   assign mem_adr = {{(wb_bus_pkg::adr_w - 26){1'b0}}, cmd_q.mem.wadr, 2'b00};

   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         state       <= wb_bus_pkg::st_idle;
         pc          <= '0;
         cmd_q       <= '0;
         acc         <= '0;
         cyc         <= 1'b0;
         stb         <= 1'b0;
         we          <= 1'b0;
         adr         <= '0;
         dat_o       <= '0;
         sel         <= '0;
         corerunning <= 1'b0;
      end else begin
         case (state)
            wb_bus_pkg::st_idle: begin
               // start seen here, first fetch goes out on the next edge
               if (start) begin
                  state <= wb_bus_pkg::st_fetch;
               end
            end

            wb_bus_pkg::st_fetch: begin
               if (!cyc) begin
                  // open the fetch transfer
                  cyc         <= 1'b1;
                  stb         <= 1'b1;
                  we          <= 1'b0;
                  adr         <= pc;
                  sel         <= '1;
                  corerunning <= 1'b1;
               end else if (ack) begin
                  // word taken on the ack edge, bus released
                  cyc   <= 1'b0;
                  stb   <= 1'b0;
                  cmd_q <= fetched;
                  pc    <= pc + 4;
                  case (fetched.mem.op)
                     wb_bus_pkg::op_ldi: begin
                        // zero extend the 28 bit immediate
                        acc   <= {4'b0000, fetched.imm.imm};
                        state <= wb_bus_pkg::st_fetch;
                     end
                     wb_bus_pkg::op_add: begin
                        state <= wb_bus_pkg::st_read;
                     end
                     wb_bus_pkg::op_store: begin
                        state <= wb_bus_pkg::st_write;
                     end
                     wb_bus_pkg::op_halt: begin
                        state       <= wb_bus_pkg::st_halted;
                        corerunning <= 1'b0;
                     end
                     default: begin
                        // unknown opcode stops the engine too
                        state       <= wb_bus_pkg::st_halted;
                        corerunning <= 1'b0;
                     end
                  endcase
               end
            end

            wb_bus_pkg::st_read: begin
               if (!cyc) begin
                  // operand read, full word
                  cyc <= 1'b1;
                  stb <= 1'b1;
                  we  <= 1'b0;
                  adr <= mem_adr;
                  sel <= '1;
               end else if (ack) begin
                  cyc   <= 1'b0;
                  stb   <= 1'b0;
                  acc   <= acc + dat_i;
                  state <= wb_bus_pkg::st_fetch;
               end
            end

            wb_bus_pkg::st_write: begin
               if (!cyc) begin
                  // store accumulator under the command's byte lanes
                  cyc   <= 1'b1;
                  stb   <= 1'b1;
                  we    <= 1'b1;
                  adr   <= mem_adr;
                  dat_o <= acc;
                  sel   <= cmd_q.mem.sel;
               end else if (ack) begin
                  cyc   <= 1'b0;
                  stb   <= 1'b0;
                  we    <= 1'b0;
                  state <= wb_bus_pkg::st_fetch;
               end
            end

            wb_bus_pkg::st_halted: begin
               // parked until reset
               cyc <= 1'b0;
               stb <= 1'b0;
               we  <= 1'b0;
            end

            default: begin
               // illegal code, park the engine
               state       <= wb_bus_pkg::st_halted;
               cyc         <= 1'b0;
               stb         <= 1'b0;
               we          <= 1'b0;
               corerunning <= 1'b0;
            end
         endcase
      end
   end

endmodule

// ==== source/serial_din.sv ====
// gated shift register that assembles a read-data word from one serial pin
`timescale 1ns/100ps

module serial_din (
   input  logic                              CLK_I,
   input  logic                              arst_n,
   input  logic                              ser_en,
   input  logic                              ser_bit,
   output logic [pin_reduce_pkg::ser_len-1:0] word
);

   // one pin and an enable stand in for the whole read-data bus
   // first bit shifted ends up in the msb after a full word

   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         word <= '0;
      end else if (ser_en) begin
         // new bit enters at the lsb
         word <= {word[pin_reduce_pkg::ser_len-2:0], ser_bit};
      end
      // enable low, word held for the engine to take on ack
   end

endmodule

// ==== source/parity_fold.sv ====
// two-stage registered xor fold of a 32-bit bus into a one-pin parity signature
`timescale 1ns/100ps

module parity_fold (
   input  logic                                CLK_I,
   input  logic                                arst_n,
   input  logic [pin_reduce_pkg::fold_in_w-1:0] bus,
   output logic                                sig
);

   // registered fold stages
   logic [pin_reduce_pkg::fold_w1-1:0] s1_q;
   logic [pin_reduce_pkg::fold_w2-1:0] s2_q;

   // next values of the stages
   logic [pin_reduce_pkg::fold_w1-1:0] s1_d;
   logic [pin_reduce_pkg::fold_w2-1:0] s2_d;

   // stage one, xor of the byte lanes
   always_comb begin
      s1_d = '0;
      for (int i = 0; i < pin_reduce_pkg::fold_lanes1; i++) begin
         s1_d ^= bus[i*pin_reduce_pkg::fold_w1 +: pin_reduce_pkg::fold_w1];
      end
   end

   // stage two, xor of the bit pairs of stage one
   always_comb begin
      s2_d = '0;
      for (int j = 0; j < pin_reduce_pkg::fold_lanes2; j++) begin
         s2_d ^= s1_q[j*pin_reduce_pkg::fold_w2 +: pin_reduce_pkg::fold_w2];
      end
   end

   always_ff @(posedge CLK_I or negedge arst_n) begin
      if (!arst_n) begin
         s1_q <= '0;
         s2_q <= '0;
      end else begin
         s1_q <= s1_d;
         s2_q <= s2_d;
      end
   end

   // parity of the bus as it was two edges ago
   assign sig = ^s2_q;

endmodule

// ==== source/wbpin_top.sv ====
// pin-reduced top: command engine, serial read-data input and two parity folds
`timescale 1ns/100ps

module wbpin_top (
   input  logic                           CLK_I,
   input  logic                           arst_n,
   input  logic                           start,
   input  logic                           ACK_I,
   input  logic                           ser_en,
   input  logic                           ser_bit,
   output logic                           CYC_O,
   output logic                           STB_O,
   output logic                           WE_O,
   output logic [wb_bus_pkg::adr_w-1:0]   ADR_O,
   output logic [wb_bus_pkg::dat_w-1:0]   DAT_O,
   output logic [wb_bus_pkg::sel_w-1:0]   SEL_O,
   output logic                           adr_sig,
   output logic                           dat_sig,
   output logic                           corerunning
);

   // read data rebuilt from the serial pin
   logic [wb_bus_pkg::dat_w-1:0] rd_word;

   cmd_sequencer u_cmd_sequencer (
      .CLK_I       (CLK_I),
      .arst_n      (arst_n),
      .start       (start),
      .ack         (ACK_I),
      .dat_i       (rd_word),
      .cyc         (CYC_O),
      .stb         (STB_O),
      .we          (WE_O),
      .adr         (ADR_O),
      .dat_o       (DAT_O),
      .sel         (SEL_O),
      .corerunning (corerunning)
   );

   // replaces the read-data pins
   serial_din u_serial_din (
      .CLK_I   (CLK_I),
      .arst_n  (arst_n),
      .ser_en  (ser_en),
      .ser_bit (ser_bit),
      .word    (rd_word)
   );

   // address bus signature
   parity_fold adr_fold (
      .CLK_I  (CLK_I),
      .arst_n (arst_n),
      .bus    (ADR_O),
      .sig    (adr_sig)
   );

   // write data signature
   parity_fold dat_fold (
      .CLK_I  (CLK_I),
      .arst_n (arst_n),
      .bus    (DAT_O),
      .sig    (dat_sig)
   );

endmodule

// ==== test/wbpin_properties.sv ====
// bound concurrent assertions on the command engine's wishbone protocol and reset state
`timescale 1ns/100ps

module wbpin_properties (
   input logic                         CLK_I,
   input logic                         arst_n,
   input logic                         cyc,
   input logic                         stb,
   input logic                         we,
   input logic                         ack,
   input logic [wb_bus_pkg::adr_w-1:0] adr,
   input logic [wb_bus_pkg::dat_w-1:0] dat_o,
   input logic [wb_bus_pkg::sel_w-1:0] sel,
   input logic                         corerunning
);

   // strobe only inside a cycle
   stb_in_cyc: assert property (@(posedge CLK_I) disable iff (!arst_n) stb |-> cyc)
      else $error("stb high without cyc");

   // cycle held until the slave acks
   cyc_held: assert property (@(posedge CLK_I) disable iff (!arst_n) (cyc && !ack) |=> cyc)
      else $error("cyc dropped before ack");

   // address and write side frozen while waiting
   bus_held: assert property (@(posedge CLK_I) disable iff (!arst_n)
      (cyc && !ack) |=> ($stable(adr) && $stable(dat_o) && $stable(sel) && $stable(we)))
      else $error("bus changed while waiting for ack");

   // reset values
   reset_quiet: assert property (@(posedge CLK_I) !arst_n |-> (!corerunning && !cyc))
      else $error("cyc or corerunning high in reset");

endmodule

bind cmd_sequencer wbpin_properties u_props (
   .CLK_I(CLK_I), .arst_n(arst_n), .cyc(cyc), .stb(stb), .we(we), .ack(ack),
   .adr(adr), .dat_o(dat_o), .sel(sel), .corerunning(corerunning)
);

// ==== test/tb_wbpin.sv ====
// testbench for wbpin_top with clock, reset, memory model, serial feeding, reference model and checks
`timescale 1ns/100ps

module tb_wbpin;

   logic        CLK_I;
   logic        arst_n;
   logic        start;
   logic        ACK_I;
   logic        ser_en;
   logic        ser_bit;
   logic        CYC_O;
   logic        STB_O;
   logic        WE_O;
   logic [31:0] ADR_O;
   logic [31:0] DAT_O;
   logic [3:0]  SEL_O;
   logic        adr_sig;
   logic        dat_sig;
   logic        corerunning;

   // bus memory, program image and the reference copy
   logic [31:0] mem [0:63];
   logic [31:0] img [0:63];
   logic [31:0] exp_mem [0:63];
   // expected writes with the oldest first
   logic [31:0] exp_wr_adr [$];
   logic [31:0] exp_wr_dat [$];
   logic [3:0]  exp_wr_sel [$];
   logic [31:0] exp_acc;
   logic [31:0] last_adr;
   logic [15:0] lfsr_state;
   int          value_errors;
   int          other_errors;
   // bus history for the signature and hold checks
   logic [31:0] adr_h1, adr_h2, dat_h1, dat_h2;
   logic [31:0] adr_prev, dat_prev;
   logic [3:0]  sel_prev;
   logic        we_prev;
   logic        wait_prev;
   int          hist_n;

   wbpin_top uut (
      .CLK_I(CLK_I), .arst_n(arst_n), .start(start), .ACK_I(ACK_I),
      .ser_en(ser_en), .ser_bit(ser_bit), .CYC_O(CYC_O), .STB_O(STB_O),
      .WE_O(WE_O), .ADR_O(ADR_O), .DAT_O(DAT_O), .SEL_O(SEL_O),
      .adr_sig(adr_sig), .dat_sig(dat_sig), .corerunning(corerunning)
   );

   initial begin
      CLK_I = 1'b0;
      forever #4 CLK_I = ~CLK_I;
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      value_errors++;
      $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
   endtask

   task automatic report_problem(input string msg);
      other_errors++;
      $display("Error at %0t: %s", $time, msg);
   endtask

   // fibonacci lfsr with taps 16 14 13 11 and one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         v = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [31:0] mem_cmd(input logic [3:0] op, input logic [3:0] sel,
                                           input int wadr);
      wb_bus_pkg::cmd_word_t c;
      c.mem.op   = op;
      c.mem.sel  = sel;
      c.mem.wadr = 24'(wadr);
      return c;
   endfunction

   function automatic logic [31:0] imm_cmd(input logic [3:0] op, input logic [27:0] imm);
      wb_bus_pkg::cmd_word_t c;
      c.imm.op  = op;
      c.imm.imm = imm;
      return c;
   endfunction

   // runs the image in mem on exp_mem and returns the byte address of the stopping command
   function automatic int run_reference();
      wb_bus_pkg::cmd_word_t c;
      logic [31:0] acc;
      logic [5:0]  widx;
      int          pc;
      acc = '0;
      pc = 0;
      exp_wr_adr.delete();
      exp_wr_dat.delete();
      exp_wr_sel.delete();
      for (int i = 0; i < 64; i++) exp_mem[i] = mem[i];
      for (int step = 0; step < 64; step++) begin
         c = exp_mem[6'(pc >> 2)];
         widx = c.mem.wadr[5:0];
         if (c.mem.op == wb_bus_pkg::op_ldi) begin
            // immediate zero extended
            acc = 32'(c.imm.imm);
         end else if (c.mem.op == wb_bus_pkg::op_add) begin
            acc = acc + exp_mem[widx];
         end else if (c.mem.op == wb_bus_pkg::op_store) begin
            exp_wr_adr.push_back(32'(c.mem.wadr) * 4);
            exp_wr_dat.push_back(acc);
            exp_wr_sel.push_back(c.mem.sel);
            // only the selected byte lanes change
            for (int b = 0; b < 4; b++)
               if (c.mem.sel[b]) exp_mem[widx][8*b +: 8] = acc[8*b +: 8];
         end else begin
            exp_acc = acc;
            return pc;
         end
         pc += 4;
      end
      exp_acc = acc;
      return -1;
   endfunction

   task automatic apply_reset();
      @(negedge CLK_I);
      arst_n = 1'b0;
      repeat (10) @(negedge CLK_I);
      arst_n = 1'b1;
   endtask

   // no transfer and no running flag for n cycles
   task automatic watch_quiet(input int n);
      repeat (n) begin
         @(negedge CLK_I);
         assert (!CYC_O) else report_problem("bus cycle started while the engine should rest");
         assert (!corerunning) else report_mismatch("corerunning", 32'(corerunning), 0);
      end
   endtask

   // one slave transfer with a random wait and read data shifted in msb first
   task automatic serve_transfer(output bit stopped);
      logic [31:0] word;
      int          waited;
      int          delay;
      stopped = 1'b0;
      waited = 0;
      while (!(CYC_O && STB_O) && waited < 200) begin
         @(negedge CLK_I);
         waited++;
      end
      if (!(CYC_O && STB_O)) begin
         report_problem("no bus transfer started before the timeout");
         stopped = 1'b1;
         return;
      end
      // engine runs while it moves words
      assert (corerunning) else report_mismatch("corerunning", 32'(corerunning), 1);
      delay = take_bits(3);
      repeat (delay) @(negedge CLK_I);
      last_adr = ADR_O;
      if (!WE_O) begin
         // fetches and operand reads use all four byte lanes
         assert (SEL_O == 4'hf) else report_mismatch("SEL_O", 32'(SEL_O), 32'hf);
         word = mem[ADR_O[7:2]];
         for (int i = pin_reduce_pkg::ser_len - 1; i >= 0; i--) begin
            ser_en = 1'b1;
            ser_bit = word[i];
            @(negedge CLK_I);
         end
         ser_en = 1'b0;
         ser_bit = 1'b0;
      end else begin
         for (int b = 0; b < 4; b++)
            if (SEL_O[b]) mem[ADR_O[7:2]][8*b +: 8] = DAT_O[8*b +: 8];
      end
      ACK_I = 1'b1;
      @(negedge CLK_I);
      ACK_I = 1'b0;
      // engine state after the ack edge
      stopped = !corerunning;
   endtask

   task automatic run_and_check();
      int halt_adr;
      bit stopped;
      for (int i = 0; i < 64; i++) mem[i] = img[i];
      halt_adr = run_reference();
      @(negedge CLK_I);
      start = 1'b1;
      @(negedge CLK_I);
      start = 1'b0;
      stopped = 1'b0;
      for (int n = 0; n < 64 && !stopped; n++) serve_transfer(stopped);
      assert (stopped) else report_problem("program did not halt within 64 transfers");
      assert (last_adr == halt_adr) else report_mismatch("halt address", last_adr, halt_adr);
      assert (uut.u_cmd_sequencer.acc == exp_acc)
         else report_mismatch("acc", uut.u_cmd_sequencer.acc, exp_acc);
      assert (exp_wr_adr.size() == 0) else report_problem("expected writes never happened");
      for (int i = 0; i < 64; i++)
         assert (mem[i] == exp_mem[i])
            else report_mismatch($sformatf("mem[%0d]", i), mem[i], exp_mem[i]);
      watch_quiet(30);
   endtask

   // comparisons on the rising edge before the flops update
   always @(posedge CLK_I) begin
      if (!arst_n) begin
         hist_n = 0;
         wait_prev = 1'b0;
      end else begin
         if (hist_n >= 2) begin
            assert (adr_sig == ^adr_h2) else report_mismatch("adr_sig", adr_sig, ^adr_h2);
            assert (dat_sig == ^dat_h2) else report_mismatch("dat_sig", dat_sig, ^dat_h2);
         end
         adr_h2 = adr_h1;
         adr_h1 = ADR_O;
         dat_h2 = dat_h1;
         dat_h1 = DAT_O;
         if (hist_n < 2) hist_n++;
         // bus held while the slave stalls
         if (wait_prev && CYC_O) begin
            assert (ADR_O == adr_prev) else report_mismatch("ADR_O", ADR_O, adr_prev);
            assert (DAT_O == dat_prev) else report_mismatch("DAT_O", DAT_O, dat_prev);
            assert (SEL_O == sel_prev) else report_mismatch("SEL_O", SEL_O, sel_prev);
            assert (WE_O == we_prev) else report_mismatch("WE_O", WE_O, we_prev);
         end
         wait_prev = CYC_O && STB_O && !ACK_I;
         adr_prev = ADR_O;
         dat_prev = DAT_O;
         sel_prev = SEL_O;
         we_prev = WE_O;
         if (CYC_O && STB_O && WE_O && ACK_I) begin
            if (exp_wr_adr.size() == 0) begin
               report_problem("write transfer that the reference does not expect");
            end else begin
               assert (ADR_O == exp_wr_adr[0]) else report_mismatch("ADR_O", ADR_O, exp_wr_adr[0]);
               assert (DAT_O == exp_wr_dat[0]) else report_mismatch("DAT_O", DAT_O, exp_wr_dat[0]);
               assert (SEL_O == exp_wr_sel[0]) else report_mismatch("SEL_O", SEL_O, exp_wr_sel[0]);
               void'(exp_wr_adr.pop_front());
               void'(exp_wr_dat.pop_front());
               void'(exp_wr_sel.pop_front());
            end
         end
      end
   end

   initial begin
      arst_n = 1'b0;
      start = 1'b0;
      ACK_I = 1'b0;
      ser_en = 1'b0;
      ser_bit = 1'b0;
      lfsr_state = 16'd9;
      value_errors = 0;
      other_errors = 0;
      last_adr = '0;
      // background words decode as unknown opcodes
      for (int i = 0; i < 64; i++) img[i] = 32'hc3000000 ^ (32'(i) * 32'h00010203);
      apply_reset();
      // engine stays idle while start is low
      watch_quiet(40);
      // load immediate, full-word store, halt
      img[0] = imm_cmd(wb_bus_pkg::op_ldi, 28'hfedcba9);
      img[1] = mem_cmd(wb_bus_pkg::op_store, 4'hf, 40);
      img[2] = mem_cmd(wb_bus_pkg::op_halt, 4'h0, 0);
      run_and_check();
      // random adds, partial stores, read back of a merged word, unknown opcode
      img[0] = imm_cmd(wb_bus_pkg::op_ldi, 28'(take_bits(28)));
      img[1] = mem_cmd(wb_bus_pkg::op_add, 4'h0, 32);
      img[2] = mem_cmd(wb_bus_pkg::op_add, 4'h0, 33);
      img[3] = mem_cmd(wb_bus_pkg::op_add, 4'h0, 34);
      img[4] = mem_cmd(wb_bus_pkg::op_store, 4'b0110, 41);
      img[5] = mem_cmd(wb_bus_pkg::op_add, 4'h0, 41);
      img[6] = mem_cmd(wb_bus_pkg::op_store, 4'b1001, 42);
      img[7] = mem_cmd(4'hc, 4'h0, 0);
      for (int i = 32; i < 35; i++) img[i] = take_bits(32);
      apply_reset();
      run_and_check();
      // same image with other ack delays
      apply_reset();
      run_and_check();
      $display("checks done, value errors %0d, other errors %0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// ==== wbpin.f ====
source/wb_bus_pkg.sv
source/pin_reduce_pkg.sv
source/cmd_sequencer.sv
source/serial_din.sv
source/parity_fold.sv
source/wbpin_top.sv
test/wbpin_properties.sv
test/tb_wbpin.sv

// ==== Bender.yml ====
package:
  name: wbpin

sources:
  - source/wb_bus_pkg.sv
  - source/pin_reduce_pkg.sv
  - source/cmd_sequencer.sv
  - source/serial_din.sv
  - source/parity_fold.sv
  - source/wbpin_top.sv
  - target: test
    files:
      - test/wbpin_properties.sv
      - test/tb_wbpin.sv
